/* all.f */
udma_fixture_pkg.sv
udma_cfg_regs.sv
udma_l2_mem.sv
udma_tx_streamer.sv
udma_rx_checker.sv
udma_fixture_top.sv
tb_udma_fixture.sv

/* Makefile */
# Verilator build and run for the uDMA HyperBus fixture

VERILATOR ?= verilator
TOP       ?= tb_udma_fixture
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_udma_fixture.sv */
/*
 * Testbench for the uDMA HyperBus channel fixture
 * Register, TX stream and RX pattern checks with assertions
 */
`timescale 1ns/100ps
`default_nettype none

module tb_udma_fixture;
    import udma_fixture_pkg::*;

    localparam int          MEM_DEPTH       = 4096;
    localparam logic [31:0] RX_PATTERN_BASE = 32'hffff_0000;
    localparam int          RESET_CYCLES    = 16;
    localparam int          FILL_BYTES      = 128;      // TX tests stay inside this window
    localparam int          TOTAL_WORDS     = 46;       // All TX and RX words of the run
    localparam int          WATCHDOG_CYCLES = 20 * TOTAL_WORDS + 2000;

    logic                  sys_clk;
    logic                  rst_n;
    logic                  cfg_valid;
    logic                  cfg_rwn;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0]     cfg_wdata;
    logic [DATA_W-1:0]     cfg_rdata;
    logic                  mem_we;
    logic [L2_ADDR_W-1:0]  mem_addr;
    logic [7:0]            mem_wdata;
    logic                  tx_ready;
    logic [DATA_W-1:0]     tx_data;
    logic                  tx_valid;
    logic [SIZE_W-1:0]     tx_bytes_left;
    logic [DATA_W-1:0]     rx_data;
    logic                  rx_valid;
    logic [SIZE_W-1:0]     rx_bytes_left;
    logic [SIZE_W-1:0]     rx_err_count;
    logic                  cmd_read;
    logic                  cmd_reg;

    integer                seed = 32'h2858;
    int                    value_errs;
    int                    assert_errs;
    logic [7:0]            ref_mem [FILL_BYTES];    // Expected L2 contents
    logic [31:0]           ca_vals [4] = '{32'd1, 32'd5, 32'd2, 32'd6};
    string                 tx_name;
    logic [L2_ADDR_W-1:0]  tx_saddr_exp;
    logic [SIZE_W-1:0]     tx_size_exp;
    int                    tx_moved;                // Words seen moving on TX
    bit                    tx_active;
    logic [SIZE_W-1:0]     rx_exp_errs;
    logic [31:0]           rd;
    logic [31:0]           rnd;
    logic [31:0]           fill_rnd;

    udma_fixture_top #(
        .MEM_DEPTH        ( MEM_DEPTH       ),
        .RX_PATTERN_BASE  ( RX_PATTERN_BASE )
    ) u_dut (
        .sys_clk          ( sys_clk         ),
        .rst_n            ( rst_n           ),
        .cfg_valid_i      ( cfg_valid       ),
        .cfg_rwn_i        ( cfg_rwn         ),
        .cfg_addr_i       ( cfg_addr        ),
        .cfg_data_i       ( cfg_wdata       ),
        .cfg_data_o       ( cfg_rdata       ),
        .mem_we_i         ( mem_we          ),
        .mem_addr_i       ( mem_addr        ),
        .mem_wdata_i      ( mem_wdata       ),
        .tx_ready_i       ( tx_ready        ),
        .tx_data_o        ( tx_data         ),
        .tx_valid_o       ( tx_valid        ),
        .tx_bytes_left_o  ( tx_bytes_left   ),
        .rx_data_i        ( rx_data         ),
        .rx_valid_i       ( rx_valid        ),
        .rx_bytes_left_o  ( rx_bytes_left   ),
        .rx_err_count_o   ( rx_err_count    ),
        .hyper_cmd_read_o ( cmd_read        ),
        .hyper_cmd_reg_o  ( cmd_reg         )
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // Random back-pressure on TX with ready about three cycles in four
    initial begin
        tx_ready = 1'b0;
        forever begin
            @(posedge sys_clk);
            #1;
            rnd      = $random(seed);
            tx_ready = (rnd[1:0] != 2'b00);
        end
    end

    //////////////////////////////////////////////////
    // Assertions and checkers
    //////////////////////////////////////////////////
    assert property (@(posedge sys_clk) !rst_n |-> (!tx_valid && rx_err_count == '0))
        else begin
            assert_errs++;
            $display("ASSERT tx_valid or the RX error count is not clear in reset at %0t", $time);
        end

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
        else begin
            assert_errs++;
            $display("ASSERT TX word dropped or changed while waiting for ready at %0t", $time);
        end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic logic [31:0] ref_word(input int addr);
        return {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
    endfunction

    function automatic logic [31:0] left_exp(input logic [SIZE_W-1:0] size, input int moved);
        int sent;
        sent = 4 * moved;
        return (int'(size) > sent) ? 32'(int'(size) - sent) : 32'd0;
    endfunction

    // TX stream monitor sampled mid-cycle
    always @(negedge sys_clk) begin
        if (rst_n && tx_active && tx_valid) begin
            check_val({tx_name, " bytes_left"}, left_exp(tx_size_exp, tx_moved),
                      32'(tx_bytes_left));
            if (tx_ready) begin
                check_val({tx_name, " data"}, ref_word(int'(tx_saddr_exp) + 4 * tx_moved),
                          tx_data);
                tx_moved++;
            end
        end else if (rst_n && !tx_active) begin
            check_val("tx_idle valid", 32'd0, 32'(tx_valid));
            check_val("tx_idle bytes_left", 32'd0, 32'(tx_bytes_left));
        end
    end

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////
    task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge sys_clk);
        #1;
        cfg_valid = 1'b1;
        cfg_rwn   = 1'b0;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge sys_clk);
        #1;
        cfg_valid = 1'b0;                               // One-cycle strobe
        cfg_rwn   = 1'b1;
    endtask

    task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge sys_clk);
        #1;
        cfg_rwn  = 1'b1;
        cfg_addr = addr;
        @(negedge sys_clk);
        data = cfg_rdata;
    endtask

    task automatic reg_check(input string name, input logic [CFG_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp);
        logic [31:0] data;
        cfg_write(addr, wdata);
        cfg_read(addr, data);
        check_val(name, exp, data);
    endtask

    task automatic run_tx(input string name, input logic [L2_ADDR_W-1:0] saddr,
                          input logic [SIZE_W-1:0] size, input bit check_busy);
        int          nwords;
        logic [31:0] st;
        nwords = (int'(size) + 3) / 4;
        cfg_write(REG_TX_SADDR, 32'(saddr));
        cfg_write(REG_TX_SIZE, 32'(size));
        tx_name      = name;
        tx_saddr_exp = saddr;
        tx_size_exp  = size;
        tx_moved     = 0;
        tx_active    = 1'b1;
        cfg_write(REG_UDMA_TXCFG, 32'h0000_0010);      // En set
        @(posedge sys_clk);
        @(negedge sys_clk);
        check_val({name, " valid after start"}, 32'd1, 32'(tx_valid));
        if (check_busy) begin
            cfg_read(REG_STATUS, st);
            check_val({name, " status busy"}, 32'd1, st);
        end
        while (tx_moved < nwords) @(posedge sys_clk);
        @(negedge sys_clk);
        check_val({name, " valid after last"}, 32'd0, 32'(tx_valid));
        tx_active = 1'b0;
        cfg_read(REG_STATUS, st);
        check_val({name, " status idle"}, 32'd0, st);
    endtask

    task automatic send_rx(input string name, input int nwords, input logic [31:0] bad_mask,
                           input bit active);
        for (int i = 0; i < nwords; i++) begin
            @(posedge sys_clk);
            #1;
            rx_valid = 1'b1;
            rx_data  = RX_PATTERN_BASE + 32'(i);
            if (bad_mask[i]) begin
                rx_data = rx_data ^ 32'h0000_0100;      // Corrupted word
            end
            if (active) begin
                @(negedge sys_clk);
                check_val({name, " bytes_left"}, 32'(4 * (nwords - i)), 32'(rx_bytes_left));
            end
        end
        @(posedge sys_clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic run_rx(input string name, input int nwords, input logic [31:0] bad_mask);
        logic [31:0] st;
        cfg_write(REG_RX_SIZE, 32'(4 * nwords));
        cfg_write(REG_UDMA_RXCFG, 32'h0000_0010);
        st = '0;
        while (!st[1]) cfg_read(REG_STATUS, st);       // Wait for rx_busy
        send_rx(name, nwords, bad_mask, 1'b1);
        while (st[1]) cfg_read(REG_STATUS, st);
        rx_exp_errs = rx_exp_errs + SIZE_W'($countones(bad_mask));
        check_val({name, " err_count"}, 32'(rx_exp_errs), 32'(rx_err_count));
        check_val({name, " bytes_left end"}, 32'd0, 32'(rx_bytes_left));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n       = 1'b0;
        cfg_valid   = 1'b0;
        cfg_rwn     = 1'b1;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        mem_we      = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        rx_data     = '0;
        rx_valid    = 1'b0;
        tx_active   = 1'b0;
        tx_moved    = 0;
        rx_exp_errs = '0;
        value_errs  = 0;
        assert_errs = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge sys_clk);
            #1;
            cfg_addr = CFG_ADDR_W'(i);
            @(negedge sys_clk);
            check_val("reset read", 32'd0, cfg_rdata);
        end
        @(posedge sys_clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 32; i++) begin
            cfg_read(CFG_ADDR_W'(i), rd);
            check_val("post reset read", 32'd0, rd);
        end

        // Read-back masks to each register's width
        reg_check("rx_saddr", REG_RX_SADDR, 32'habcd_e123, 32'h0000_0123);
        reg_check("rx_size", REG_RX_SIZE, 32'h1234_5678, 32'h0000_5678);
        reg_check("tx_saddr", REG_TX_SADDR, 32'hffff_f456, 32'h0000_0456);
        reg_check("tx_size", REG_TX_SIZE, 32'h5a5a_abcd, 32'h0000_abcd);
        foreach (ca_vals[k]) begin
            reg_check("ca_setup", REG_HYPER_CA_SETUP, ca_vals[k], ca_vals[k]);
            check_val("cmd_read", 32'(ca_vals[k][2]), 32'(cmd_read));
            check_val("cmd_reg", 32'(ca_vals[k][1]), 32'(cmd_reg));
        end

        for (int a = 0; a < FILL_BYTES; a++) begin
            @(negedge sys_clk);
            fill_rnd   = $random(seed);
            @(posedge sys_clk);
            #1;
            mem_we     = 1'b1;
            mem_addr   = L2_ADDR_W'(a);
            mem_wdata  = fill_rnd[7:0];
            ref_mem[a] = fill_rnd[7:0];
        end
        @(posedge sys_clk);
        #1;
        mem_we = 1'b0;

        run_tx("tx_content", 12'h010, 16'd64, 1'b1);
        run_tx("tx_len16", 12'h020, 16'd16, 1'b0);
        run_tx("tx_len18", 12'h031, 16'd18, 1'b0);     // Unaligned start
        run_tx("tx_len3", 12'h05d, 16'd3, 1'b0);

        run_rx("rx_pattern", 8, 32'h0000_0024);         // Words 2 and 5 bad
        run_rx("rx_clean", 8, 32'h0000_0000);
        send_rx("rx_idle", 4, 32'h0000_000f, 1'b0);
        @(negedge sys_clk);
        check_val("rx_idle err_count", 32'(rx_exp_errs), 32'(rx_err_count));

        $display("Checks: %0d value mismatches, %0d assertion failures", value_errs, assert_errs);
        if (value_errs + assert_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d value mismatches, %0d assertion failures", value_errs, assert_errs);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* udma_fixture_top.sv */
/*
 * uDMA HyperBus channel fixture, L2 side
 * Config registers, L2 memory, TX streamer and RX checker
 */
`timescale 1ns/100ps
`default_nettype none

module udma_fixture_top #(
    parameter int                                   MEM_DEPTH       = 4096,
    parameter logic [udma_fixture_pkg::DATA_W-1:0]  RX_PATTERN_BASE = 32'hffff_0000
) (
    input  wire                                     sys_clk,
    input  wire                                     rst_n,
    input  wire                                     cfg_valid_i,
    input  wire                                     cfg_rwn_i,
    input  wire  [udma_fixture_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire  [udma_fixture_pkg::DATA_W-1:0]     cfg_data_i,
    output logic [udma_fixture_pkg::DATA_W-1:0]     cfg_data_o,
    input  wire                                     mem_we_i,
    input  wire  [udma_fixture_pkg::L2_ADDR_W-1:0]  mem_addr_i,
    input  wire  [7:0]                              mem_wdata_i,
    input  wire                                     tx_ready_i,
    output logic [udma_fixture_pkg::DATA_W-1:0]     tx_data_o,
    output logic                                    tx_valid_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     tx_bytes_left_o,
    input  wire  [udma_fixture_pkg::DATA_W-1:0]     rx_data_i,
    input  wire                                     rx_valid_i,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     rx_bytes_left_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     rx_err_count_o,
    output logic                                    hyper_cmd_read_o,
    output logic                                    hyper_cmd_reg_o
);
    import udma_fixture_pkg::*;

    logic                  tx_start;
    logic                  rx_start;
    logic                  tx_busy;
    logic                  rx_busy;
    logic [L2_ADDR_W-1:0]  tx_saddr;
    logic [SIZE_W-1:0]     tx_size;
    logic [SIZE_W-1:0]     rx_size;
    logic [L2_ADDR_W-1:0]  rd_addr;
    logic [DATA_W-1:0]     rd_data;

    udma_cfg_regs u_cfg_regs (
        .sys_clk          ( sys_clk          ),
        .rst_n            ( rst_n            ),
        .cfg_valid_i      ( cfg_valid_i      ),
        .cfg_rwn_i        ( cfg_rwn_i        ),
        .cfg_addr_i       ( cfg_addr_i       ),
        .cfg_data_i       ( cfg_data_i       ),
        .tx_busy_i        ( tx_busy          ),
        .rx_busy_i        ( rx_busy          ),
        .cfg_data_o       ( cfg_data_o       ),
        .tx_start_o       ( tx_start         ),
        .rx_start_o       ( rx_start         ),
        .tx_saddr_o       ( tx_saddr         ),
        .tx_size_o        ( tx_size          ),
        .rx_saddr_o       (                  ),  // RX lands outside L2 here
        .rx_size_o        ( rx_size          ),
        .hyper_cmd_read_o ( hyper_cmd_read_o ),
        .hyper_cmd_reg_o  ( hyper_cmd_reg_o  )
    );

    udma_l2_mem #(
        .MEM_DEPTH        ( MEM_DEPTH        )
    ) u_l2_mem (
        .sys_clk          ( sys_clk          ),
        .mem_we_i         ( mem_we_i         ),
        .mem_addr_i       ( mem_addr_i       ),
        .mem_wdata_i      ( mem_wdata_i      ),
        .rd_addr_i        ( rd_addr          ),
        .rd_data_o        ( rd_data          )
    );

    udma_tx_streamer u_tx_streamer (
        .sys_clk          ( sys_clk          ),
        .rst_n            ( rst_n            ),
        .start_i          ( tx_start         ),
        .saddr_i          ( tx_saddr         ),
        .size_i           ( tx_size          ),
        .rd_data_i        ( rd_data          ),
        .tx_ready_i       ( tx_ready_i       ),
        .rd_addr_o        ( rd_addr          ),
        .tx_data_o        ( tx_data_o        ),
        .tx_valid_o       ( tx_valid_o       ),
        .busy_o           ( tx_busy          ),
        .bytes_left_o     ( tx_bytes_left_o  )
    );

    udma_rx_checker #(
        .RX_PATTERN_BASE  ( RX_PATTERN_BASE  )
    ) u_rx_checker (
        .sys_clk          ( sys_clk          ),
        .rst_n            ( rst_n            ),
        .start_i          ( rx_start         ),
        .size_i           ( rx_size          ),
        .rx_data_i        ( rx_data_i        ),
        .rx_valid_i       ( rx_valid_i       ),
        .busy_o           ( rx_busy          ),
        .bytes_left_o     ( rx_bytes_left_o  ),
        .err_count_o      ( rx_err_count_o   )
    );

endmodule

`default_nettype wire

/* udma_rx_checker.sv */
/*
 * uDMA RX checker
 * Counts incoming words and compares them to a running pattern
 */
`timescale 1ns/100ps
`default_nettype none

module udma_rx_checker #(
    parameter logic [udma_fixture_pkg::DATA_W-1:0] RX_PATTERN_BASE = 32'hffff_0000
) (
    input  wire                                     sys_clk,
    input  wire                                     rst_n,
    input  wire                                     start_i,
    input  wire  [udma_fixture_pkg::SIZE_W-1:0]     size_i,
    input  wire  [udma_fixture_pkg::DATA_W-1:0]     rx_data_i,
    input  wire                                     rx_valid_i,
    output logic                                    busy_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     bytes_left_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     err_count_o
);
    import udma_fixture_pkg::*;

    logic                  busy_q;
    logic [SIZE_W-1:0]     size_q;
    logic [SIZE_W-1:0]     word_cnt_q;   // Words received so far
    logic [SIZE_W-1:0]     err_q;
    logic [SIZE_W-1:0]     rcvd_bytes;
    logic [SIZE_W-1:0]     remain;
    logic [DATA_W-1:0]     expected;
    logic                  word;
    logic                  mismatch;

    assign rcvd_bytes = SIZE_W'(word_cnt_q * BYTES_PER_WORD);
    assign remain     = (size_q > rcvd_bytes) ? size_q - rcvd_bytes : '0;
    assign expected   = RX_PATTERN_BASE + DATA_W'(word_cnt_q);
    assign word       = busy_q & rx_valid_i;    // Idle words are dropped
    assign mismatch   = word & (rx_data_i != expected);

    //////////////////////////////////////////////////
    // Transfer tracking and error count
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            size_q     <= '0;
            word_cnt_q <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q     <= 1'b1;
                size_q     <= size_i;
                word_cnt_q <= '0;
            end
        end else if (word) begin
            if (remain <= SIZE_W'(BYTES_PER_WORD)) begin
                busy_q <= 1'b0;                     // Last word of the transfer
            end
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    // Kept across transfers and saturating at all ones
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= '0;
        end else if (mismatch && (err_q != '1)) begin
            err_q <= err_q + 1'b1;
        end
    end

    assign busy_o       = busy_q;
    assign bytes_left_o = busy_q ? remain : '0;
    assign err_count_o  = err_q;

endmodule

`default_nettype wire

/* udma_tx_streamer.sv */
/*
 * uDMA TX streamer
 * Walks L2 word by word and streams it out under valid/ready
 */
`timescale 1ns/100ps
`default_nettype none

module udma_tx_streamer (
    input  wire                                     sys_clk,
    input  wire                                     rst_n,
    input  wire                                     start_i,
    input  wire  [udma_fixture_pkg::L2_ADDR_W-1:0]  saddr_i,
    input  wire  [udma_fixture_pkg::SIZE_W-1:0]     size_i,
    input  wire  [udma_fixture_pkg::DATA_W-1:0]     rd_data_i,
    input  wire                                     tx_ready_i,
    output logic [udma_fixture_pkg::L2_ADDR_W-1:0]  rd_addr_o,
    output logic [udma_fixture_pkg::DATA_W-1:0]     tx_data_o,
    output logic                                    tx_valid_o,
    output logic                                    busy_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     bytes_left_o
);
    import udma_fixture_pkg::*;

    logic                  busy_q;
    logic [L2_ADDR_W-1:0]  addr_q;
    logic [SIZE_W-1:0]     size_q;
    logic [SIZE_W-1:0]     sent_q;       // Bytes already moved
    logic [SIZE_W-1:0]     remain;
    logic                  beat;
    logic                  last_beat;

    assign remain    = (size_q > sent_q) ? size_q - sent_q : '0;
    assign beat      = busy_q & tx_ready_i;
    assign last_beat = (remain <= SIZE_W'(BYTES_PER_WORD));

    //////////////////////////////////////////////////
    // Transfer control
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            addr_q <= '0;
            size_q <= '0;
            sent_q <= '0;
        end else if (!busy_q) begin
            if (start_i) begin                      // Starts ignored while running
                busy_q <= 1'b1;
                addr_q <= saddr_i;
                size_q <= size_i;
                sent_q <= '0;
            end
        end else if (beat) begin
            if (last_beat) begin
                busy_q <= 1'b0;                     // Valid drops after last word
            end
            addr_q <= addr_q + L2_ADDR_W'(BYTES_PER_WORD);
            sent_q <= sent_q + SIZE_W'(BYTES_PER_WORD);
        end
    end

    // Word is held at the same address until it moves
    assign rd_addr_o    = addr_q;
    assign tx_data_o    = rd_data_i;
    assign tx_valid_o   = busy_q;
    assign busy_o       = busy_q;
    assign bytes_left_o = busy_q ? remain : '0;

endmodule

`default_nettype wire

/* udma_l2_mem.sv */
/*
 * L2 data memory
 * Byte write port from outside, 32-bit little-endian word read for TX
 */
`timescale 1ns/100ps
`default_nettype none

module udma_l2_mem #(
    parameter int MEM_DEPTH = 4096
) (
    input  wire                                     sys_clk,
    input  wire                                     mem_we_i,
    input  wire  [udma_fixture_pkg::L2_ADDR_W-1:0]  mem_addr_i,
    input  wire  [7:0]                              mem_wdata_i,
    input  wire  [udma_fixture_pkg::L2_ADDR_W-1:0]  rd_addr_i,
    output logic [udma_fixture_pkg::DATA_W-1:0]     rd_data_o
);
    import udma_fixture_pkg::*;

    logic [7:0] mem_q [MEM_DEPTH];

    //////////////////////////////////////////////////
    // Byte write
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (mem_we_i) begin
            mem_q[int'(mem_addr_i) % MEM_DEPTH] <= mem_wdata_i;
        end
    end

    //////////////////////////////////////////////////
    // Word read
    //////////////////////////////////////////////////
    // Byte at rd_addr_i lands in the low lane and the address wraps at the top
    for (genvar b = 0; b < BYTES_PER_WORD; b++) begin : g_rd_lane
        assign rd_data_o[8*b +: 8] = mem_q[(int'(rd_addr_i) + b) % MEM_DEPTH];
    end

endmodule

`default_nettype wire

/* udma_cfg_regs.sv */
/*
 * uDMA channel configuration registers
 * Cfg bus write and read-back, TX/RX start pulses, command decode
 */
`timescale 1ns/100ps
`default_nettype none

module udma_cfg_regs (
    input  wire                                     sys_clk,
    input  wire                                     rst_n,
    input  wire                                     cfg_valid_i,
    input  wire                                     cfg_rwn_i,
    input  wire  [udma_fixture_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire  [udma_fixture_pkg::DATA_W-1:0]     cfg_data_i,
    input  wire                                     tx_busy_i,
    input  wire                                     rx_busy_i,
    output logic [udma_fixture_pkg::DATA_W-1:0]     cfg_data_o,
    output logic                                    tx_start_o,
    output logic                                    rx_start_o,
    output logic [udma_fixture_pkg::L2_ADDR_W-1:0]  tx_saddr_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     tx_size_o,
    output logic [udma_fixture_pkg::L2_ADDR_W-1:0]  rx_saddr_o,
    output logic [udma_fixture_pkg::SIZE_W-1:0]     rx_size_o,
    output logic                                    hyper_cmd_read_o,
    output logic                                    hyper_cmd_reg_o
);
    import udma_fixture_pkg::*;

    cfg_word_u            cfg_word;
    cfg_word_u            ca_setup_q;
    cfg_word_u            tx_cfg_rd;
    cfg_word_u            rx_cfg_rd;
    logic                 cfg_wr;
    logic [2:0]           tx_mode_q;     // {datasize, continuous}
    logic [2:0]           rx_mode_q;
    logic                 tx_start_q;
    logic                 rx_start_q;

    assign cfg_word = cfg_data_i;
    assign cfg_wr   = cfg_valid_i & ~cfg_rwn_i;

    //////////////////////////////////////////////////
    // Register writes and start pulses
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_saddr_o <= '0;
            rx_size_o  <= '0;
            rx_mode_q  <= '0;
            tx_saddr_o <= '0;
            tx_size_o  <= '0;
            tx_mode_q  <= '0;
            ca_setup_q <= '0;
            tx_start_q <= 1'b0;
            rx_start_q <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;                     // One-cycle pulses
            rx_start_q <= 1'b0;
            if (cfg_wr) begin
                case (cfg_addr_i)
                    REG_RX_SADDR:       rx_saddr_o <= cfg_data_i[L2_ADDR_W-1:0];
                    REG_RX_SIZE:        rx_size_o  <= cfg_data_i[SIZE_W-1:0];
                    REG_TX_SADDR:       tx_saddr_o <= cfg_data_i[L2_ADDR_W-1:0];
                    REG_TX_SIZE:        tx_size_o  <= cfg_data_i[SIZE_W-1:0];
                    REG_HYPER_CA_SETUP: ca_setup_q <= cfg_word;
                    REG_UDMA_RXCFG: begin
                        rx_mode_q  <= {cfg_word.udma.datasize, cfg_word.udma.continuous};
                        rx_start_q <= cfg_word.udma.en & (rx_size_o != '0);
                    end
                    REG_UDMA_TXCFG: begin
                        tx_mode_q  <= {cfg_word.udma.datasize, cfg_word.udma.continuous};
                        tx_start_q <= cfg_word.udma.en & (tx_size_o != '0);
                    end
                    default: ;                      // Read-only or unmapped
                endcase
            end
        end
    end

    assign tx_start_o = tx_start_q;
    assign rx_start_o = rx_start_q;

    // Command levels from the stored CA setup
    assign hyper_cmd_read_o = ca_setup_q.ca.read;
    assign hyper_cmd_reg_o  = ca_setup_q.ca.reg_space;

    //////////////////////////////////////////////////
    // Read-back
    //////////////////////////////////////////////////
    always_comb begin
        tx_cfg_rd                 = '0;
        tx_cfg_rd.udma.datasize   = tx_mode_q[2:1];
        tx_cfg_rd.udma.continuous = tx_mode_q[0];
        tx_cfg_rd.udma.en         = tx_busy_i;      // En reads back as running
        rx_cfg_rd                 = '0;
        rx_cfg_rd.udma.datasize   = rx_mode_q[2:1];
        rx_cfg_rd.udma.continuous = rx_mode_q[0];
        rx_cfg_rd.udma.en         = rx_busy_i;
    end

    always_comb begin
        case (cfg_addr_i)
            REG_RX_SADDR:       cfg_data_o = DATA_W'(rx_saddr_o);
            REG_RX_SIZE:        cfg_data_o = DATA_W'(rx_size_o);
            REG_UDMA_RXCFG:     cfg_data_o = rx_cfg_rd;
            REG_TX_SADDR:       cfg_data_o = DATA_W'(tx_saddr_o);
            REG_TX_SIZE:        cfg_data_o = DATA_W'(tx_size_o);
            REG_UDMA_TXCFG:     cfg_data_o = tx_cfg_rd;
            REG_HYPER_CA_SETUP: cfg_data_o = ca_setup_q;
            REG_STATUS:         cfg_data_o = {{(DATA_W-2){1'b0}}, rx_busy_i, tx_busy_i};
            default:            cfg_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* udma_fixture_pkg.sv */
/*
 * uDMA HyperBus fixture shared definitions
 * Widths, register map and the config word decode
 */
`default_nettype none

package udma_fixture_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int CFG_ADDR_W     = 5;
    localparam int DATA_W         = 32;
    localparam int L2_ADDR_W      = 12;     // L2 byte address
    localparam int SIZE_W         = 16;     // Transfer size in bytes
    localparam int BYTES_PER_WORD = 4;

    //////////////////////////////////////////////////
    // Channel register map
    //////////////////////////////////////////////////
    localparam logic [CFG_ADDR_W-1:0] REG_RX_SADDR       = 5'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_RX_SIZE        = 5'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_UDMA_RXCFG     = 5'd2;
    localparam logic [CFG_ADDR_W-1:0] REG_TX_SADDR       = 5'd3;
    localparam logic [CFG_ADDR_W-1:0] REG_TX_SIZE        = 5'd4;
    localparam logic [CFG_ADDR_W-1:0] REG_UDMA_TXCFG     = 5'd5;
    localparam logic [CFG_ADDR_W-1:0] REG_HYPER_CA_SETUP = 5'd6;
    localparam logic [CFG_ADDR_W-1:0] REG_STATUS         = 5'd9;

    // One cfg word seen either as a uDMA channel config or as a CA setup
    // CA values 1 mem write, 5 mem read, 2 reg write and 6 reg read
    typedef union packed {
        struct packed {
            logic [25:0] rsvd_hi;
            logic        clr;           // Bit 5
            logic        en;            // Bit 4
            logic        rsvd_lo;
            logic [1:0]  datasize;      // Bits 2:1
            logic        continuous;    // Bit 0
        } udma;
        struct packed {
            logic [28:0] rsvd_hi;
            logic        read;          // Bit 2
            logic        reg_space;     // Bit 1
            logic        rsvd_lo;
        } ca;
    } cfg_word_u;

endpackage

`default_nettype wire
